//--- ss_pkg.sv
package ss_pkg;

  // Bus widths
  localparam int SS_DATA_W   = 32;
  localparam int SS_ADDR_W   = 8;
  localparam int SS_REGION_W = 2;
  localparam int SS_OFFSET_W = SS_ADDR_W - SS_REGION_W;

  // One save-state address, seen as a counter or as bank select
  typedef union packed {
    logic [SS_ADDR_W-1:0] flat;
    struct packed {
      logic [SS_REGION_W-1:0] region;
      logic [SS_OFFSET_W-1:0] offset;
    } split;
  } ss_addr_u;

  // Bridge register window
  localparam logic [31:0] SS_REG_CMD       = 32'd0;
  localparam logic [31:0] SS_REG_STATUS    = 32'd4;
  localparam logic [31:0] SS_REG_SAVE_DATA = 32'd8;
  localparam logic [31:0] SS_REG_LOAD_DATA = 32'd12;

  // Command register bits
  localparam int SS_CMD_SAVE_BIT = 0;
  localparam int SS_CMD_LOAD_BIT = 1;

  // Status register bits
  localparam int SS_ST_SAVE_ACK  = 0;
  localparam int SS_ST_SAVE_BUSY = 1;
  localparam int SS_ST_SAVE_OK   = 2;
  localparam int SS_ST_SAVE_ERR  = 3;
  localparam int SS_ST_LOAD_ACK  = 4;
  localparam int SS_ST_LOAD_BUSY = 5;
  localparam int SS_ST_LOAD_OK   = 6;
  localparam int SS_ST_LOAD_ERR  = 7;

endpackage

//--- ss_bridge_regs.sv
module ss_bridge_regs (
  input  logic                         clk_sys,
  input  logic                         rst_n,
  input  logic                         bridge_wr,
  input  logic                         bridge_rd,
  input  logic [31:0]                  bridge_addr,
  input  logic [31:0]                  bridge_wr_data,
  output logic [31:0]                  bridge_rd_data,
  output logic                         save_go,
  output logic                         load_go,
  input  logic [ss_pkg::SS_DATA_W-1:0] save_word,
  input  logic                         save_word_valid,
  output logic                         save_word_taken,
  output logic [ss_pkg::SS_DATA_W-1:0] load_word,
  output logic                         load_word_valid,
  input  logic                         load_word_taken,
  input  logic                         save_busy,
  input  logic                         load_busy,
  input  logic                         save_done,
  input  logic                         load_done,
  input  logic                         save_fail
);

  logic        save_ack;
  logic        save_ok;
  logic        save_err;
  logic        load_ack;
  logic        load_ok;
  logic        load_err;
  logic [31:0] status_word;
  logic        cmd_wr;
  logic        save_cmd;
  logic        load_cmd;
  logic        engines_idle;

  // Host sees words most significant nibble last
  function automatic logic [31:0] nibble_swap(input logic [31:0] w);
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i*4 +: 4] = w[(7-i)*4 +: 4];
    end
    return r;
  endfunction

  assign cmd_wr   = bridge_wr && (bridge_addr == ss_pkg::SS_REG_CMD);
  assign save_cmd = cmd_wr && bridge_wr_data[ss_pkg::SS_CMD_SAVE_BIT];
  assign load_cmd = cmd_wr && bridge_wr_data[ss_pkg::SS_CMD_LOAD_BIT];

  // A go still in flight counts as busy
  assign engines_idle = !save_busy && !load_busy && !save_go && !load_go;

  always_comb begin
    status_word = '0;
    status_word[ss_pkg::SS_ST_SAVE_ACK]  = save_ack;
    status_word[ss_pkg::SS_ST_SAVE_BUSY] = save_busy;
    status_word[ss_pkg::SS_ST_SAVE_OK]   = save_ok;
    status_word[ss_pkg::SS_ST_SAVE_ERR]  = save_err;
    status_word[ss_pkg::SS_ST_LOAD_ACK]  = load_ack;
    status_word[ss_pkg::SS_ST_LOAD_BUSY] = load_busy;
    status_word[ss_pkg::SS_ST_LOAD_OK]   = load_ok;
    status_word[ss_pkg::SS_ST_LOAD_ERR]  = load_err;
  end

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      save_go  <= 1'b0;
      load_go  <= 1'b0;
      save_ack <= 1'b0;
      load_ack <= 1'b0;
      save_ok  <= 1'b0;
      save_err <= 1'b0;
      load_ok  <= 1'b0;
      load_err <= 1'b0;
    end else begin
      save_go  <= 1'b0;
      load_go  <= 1'b0;
      save_ack <= save_go;
      load_ack <= load_go;
      // Save wins when both bits are written together
      if (save_cmd) begin
        if (engines_idle) begin
          save_go  <= 1'b1;
          save_ok  <= 1'b0;
          save_err <= 1'b0;
          load_ok  <= 1'b0;
          load_err <= 1'b0;
        end else begin
          save_err <= 1'b1;
        end
      end else if (load_cmd) begin
        if (engines_idle) begin
          load_go  <= 1'b1;
          load_ok  <= 1'b0;
          load_err <= 1'b0;
          save_ok  <= 1'b0;
          save_err <= 1'b0;
        end else begin
          load_err <= 1'b1;
        end
      end
      if (save_done) save_ok <= 1'b1;
      if (save_fail) save_err <= 1'b1;
      if (load_done) load_ok <= 1'b1;
    end
  end

  // Read port and save-word handoff
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      bridge_rd_data  <= '0;
      save_word_taken <= 1'b0;
    end else begin
      save_word_taken <= bridge_rd && save_word_valid &&
                         (bridge_addr == ss_pkg::SS_REG_SAVE_DATA);
      if (bridge_rd) begin
        case (bridge_addr)
          ss_pkg::SS_REG_STATUS:    bridge_rd_data <= status_word;
          ss_pkg::SS_REG_SAVE_DATA: bridge_rd_data <= nibble_swap(save_word);
          ss_pkg::SS_REG_LOAD_DATA: bridge_rd_data <= nibble_swap(load_word);
          default:                  bridge_rd_data <= '0;
        endcase
      end
    end
  end

  // Load word holding register
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      load_word_valid <= 1'b0;
    end else if (bridge_wr && (bridge_addr == ss_pkg::SS_REG_LOAD_DATA)) begin
      load_word_valid <= 1'b1;
    end else if (load_word_taken) begin
      load_word_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (bridge_wr && (bridge_addr == ss_pkg::SS_REG_LOAD_DATA)) begin
      load_word <= nibble_swap(bridge_wr_data);
    end
  end

endmodule

//--- ss_save_engine.sv
module ss_save_engine #(
  parameter int SS_WORDS     = 192,
  parameter int READ_LATENCY = 10
) (
  input  logic                         clk_sys,
  input  logic                         rst_n,
  input  logic                         save_go,
  input  logic                         save_word_taken,
  input  logic                         sess_gnt,
  input  logic                         ss_ready,
  input  logic [ss_pkg::SS_DATA_W-1:0] bus_rdata,
  output logic                         sess_req,
  output logic [ss_pkg::SS_ADDR_W-1:0] bus_addr,
  output logic [ss_pkg::SS_DATA_W-1:0] save_word,
  output logic                         save_word_valid,
  output logic                         save_busy,
  output logic                         save_done,
  output logic                         save_fail
);

  localparam int LAT_W = $clog2(READ_LATENCY + 1);

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_WAIT_READY = 3'd1;
  localparam logic [2:0] ST_READ       = 3'd2;
  localparam logic [2:0] ST_WAIT_TAKEN = 3'd3;
  localparam logic [2:0] ST_FINISH     = 3'd4;

  logic [2:0]       state;
  ss_pkg::ss_addr_u addr_q;
  logic [LAT_W-1:0] lat_cnt;
  logic [7:0]       ready_timer;

  assign bus_addr  = addr_q.flat;
  assign sess_req  = (state == ST_WAIT_READY) || (state == ST_READ) ||
                     (state == ST_WAIT_TAKEN);
  assign save_busy = (state != ST_IDLE);
  assign save_done = (state == ST_FINISH);

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      state           <= ST_IDLE;
      addr_q.flat     <= '0;
      lat_cnt         <= '0;
      ready_timer     <= '0;
      save_word_valid <= 1'b0;
      save_fail       <= 1'b0;
    end else begin
      save_fail <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (save_go) begin
            addr_q.flat <= '0;
            ready_timer <= '0;
            state       <= ST_WAIT_READY;
          end
        end
        ST_WAIT_READY: begin
          if (sess_gnt && ss_ready) begin
            lat_cnt <= '0;
            state   <= ST_READ;
          end else if (ready_timer == 8'd255) begin
            // Machine never halted
            save_fail <= 1'b1;
            state     <= ST_IDLE;
          end else begin
            ready_timer <= ready_timer + 8'd1;
          end
        end
        ST_READ: begin
          if (lat_cnt == LAT_W'(READ_LATENCY)) begin
            save_word_valid <= 1'b1;
            state           <= ST_WAIT_TAKEN;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        ST_WAIT_TAKEN: begin
          // Hold here until the host has read the word
          if (save_word_taken) begin
            save_word_valid <= 1'b0;
            if (addr_q.flat == ss_pkg::SS_ADDR_W'(SS_WORDS - 1)) begin
              state <= ST_FINISH;
            end else begin
              addr_q.flat <= addr_q.flat + 1'b1;
              lat_cnt     <= '0;
              state       <= ST_READ;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state == ST_READ && lat_cnt == LAT_W'(READ_LATENCY)) begin
      save_word <= bus_rdata;
    end
  end

endmodule

//--- ss_load_engine.sv
module ss_load_engine #(
  parameter int SS_WORDS = 192
) (
  input  logic                         clk_sys,
  input  logic                         rst_n,
  input  logic                         load_go,
  input  logic [ss_pkg::SS_DATA_W-1:0] load_word,
  input  logic                         load_word_valid,
  input  logic                         sess_gnt,
  input  logic                         ss_ready,
  output logic                         sess_req,
  output logic [ss_pkg::SS_ADDR_W-1:0] bus_addr,
  output logic [ss_pkg::SS_DATA_W-1:0] bus_wdata,
  output logic                         bus_wren,
  output logic                         load_word_taken,
  output logic                         load_busy,
  output logic                         load_done
);

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_WAIT_READY = 3'd1;
  localparam logic [2:0] ST_WAIT_WORD  = 3'd2;
  localparam logic [2:0] ST_WRITE      = 3'd3;
  localparam logic [2:0] ST_FINISH     = 3'd4;

  logic [2:0]       state;
  ss_pkg::ss_addr_u addr_q;

  assign bus_addr        = addr_q.flat;
  assign sess_req        = (state == ST_WAIT_READY) || (state == ST_WAIT_WORD) ||
                           (state == ST_WRITE);
  // Word is written and released in the same cycle
  assign bus_wren        = (state == ST_WRITE);
  assign load_word_taken = (state == ST_WRITE);
  assign load_busy       = (state != ST_IDLE);
  assign load_done       = (state == ST_FINISH);

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      addr_q.flat <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (load_go) begin
            addr_q.flat <= '0;
            state       <= ST_WAIT_READY;
          end
        end
        ST_WAIT_READY: begin
          if (sess_gnt && ss_ready) state <= ST_WAIT_WORD;
        end
        ST_WAIT_WORD: begin
          if (load_word_valid) state <= ST_WRITE;
        end
        ST_WRITE: begin
          if (addr_q.flat == ss_pkg::SS_ADDR_W'(SS_WORDS - 1)) begin
            state <= ST_FINISH;
          end else begin
            addr_q.flat <= addr_q.flat + 1'b1;
            state       <= ST_WAIT_WORD;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state == ST_WAIT_WORD && load_word_valid) begin
      bus_wdata <= load_word;
    end
  end

endmodule

//--- ss_bus_arbiter.sv
module ss_bus_arbiter (
  input  logic                         clk_sys,
  input  logic                         rst_n,
  input  logic                         save_req,
  input  logic                         load_req,
  output logic                         save_gnt,
  output logic                         load_gnt,
  input  logic [ss_pkg::SS_ADDR_W-1:0] save_addr,
  input  logic [ss_pkg::SS_ADDR_W-1:0] load_addr,
  input  logic [ss_pkg::SS_DATA_W-1:0] load_wdata,
  input  logic                         load_wren,
  input  logic                         ss_ready,
  output logic                         save_ready,
  output logic                         load_ready,
  output logic [ss_pkg::SS_ADDR_W-1:0] bus_addr,
  output logic [ss_pkg::SS_DATA_W-1:0] bus_wdata,
  output logic                         bus_wren,
  output logic                         ss_halt
);

  // Grant is held for the whole session, save first on a tie
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      save_gnt <= 1'b0;
      load_gnt <= 1'b0;
    end else if (save_gnt) begin
      save_gnt <= save_req;
    end else if (load_gnt) begin
      load_gnt <= load_req;
    end else if (save_req) begin
      save_gnt <= 1'b1;
    end else if (load_req) begin
      load_gnt <= 1'b1;
    end
  end

  assign ss_halt    = save_gnt || load_gnt;
  assign save_ready = save_gnt && ss_ready;
  assign load_ready = load_gnt && ss_ready;

  // Save only reads, so writes come from the load side alone
  assign bus_addr  = load_gnt ? load_addr : save_addr;
  assign bus_wdata = load_gnt ? load_wdata : '0;
  assign bus_wren  = load_gnt && load_wren;

endmodule

//--- ss_state_store.sv
module ss_state_store #(
  parameter int SS_WORDS     = 192,
  parameter int READ_LATENCY = 10,
  parameter int READY_DELAY  = 6
) (
  input  logic                         clk_sys,
  input  logic                         rst_n,
  input  logic                         ss_halt,
  input  logic [ss_pkg::SS_ADDR_W-1:0] bus_addr,
  input  logic [ss_pkg::SS_DATA_W-1:0] bus_wdata,
  input  logic                         bus_wren,
  output logic [ss_pkg::SS_DATA_W-1:0] bus_rdata,
  output logic                         ss_ready
);

  localparam int BANKS      = 2 ** ss_pkg::SS_REGION_W;
  localparam int BANK_DEPTH = 2 ** ss_pkg::SS_OFFSET_W;
  localparam int RDY_W      = $clog2(READY_DELAY + 1);

  ss_pkg::ss_addr_u            addr;
  logic [ss_pkg::SS_DATA_W-1:0] bank [BANKS][BANK_DEPTH];
  logic [ss_pkg::SS_DATA_W-1:0] rd_pipe [READ_LATENCY];
  logic [RDY_W-1:0]             rdy_cnt;

  assign addr.flat = bus_addr;

  // Region picks the bank, offset the word inside it
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < BANKS; r++) begin
        for (int o = 0; o < BANK_DEPTH; o++) begin
          if (r * BANK_DEPTH + o < SS_WORDS) begin
            bank[r][o] <= (r * BANK_DEPTH + o) * 32'h0101_0101;
          end else begin
            bank[r][o] <= '0;
          end
        end
      end
    end else if (ss_halt && bus_wren && (int'(addr.flat) < SS_WORDS)) begin
      bank[addr.split.region][addr.split.offset] <= bus_wdata;
    end
  end

  // Fixed read latency
  always_ff @(posedge clk_sys) begin
    rd_pipe[0] <= bank[addr.split.region][addr.split.offset];
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign bus_rdata = rd_pipe[READ_LATENCY-1];

  // Machine takes a few cycles to settle after halt
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      rdy_cnt <= '0;
    end else if (!ss_halt) begin
      rdy_cnt <= '0;
    end else if (rdy_cnt != RDY_W'(READY_DELAY)) begin
      rdy_cnt <= rdy_cnt + 1'b1;
    end
  end

  assign ss_ready = ss_halt && (rdy_cnt == RDY_W'(READY_DELAY));

endmodule

//--- ss_top.sv
module ss_top #(
  parameter int SS_WORDS     = 192,
  parameter int READ_LATENCY = 10,
  parameter int READY_DELAY  = 6
) (
  input  logic        clk_sys,
  input  logic        rst_n,
  input  logic        bridge_wr,
  input  logic        bridge_rd,
  input  logic [31:0] bridge_addr,
  input  logic [31:0] bridge_wr_data,
  output logic [31:0] bridge_rd_data
);

  logic                         save_go;
  logic                         load_go;
  logic [ss_pkg::SS_DATA_W-1:0] save_word;
  logic                         save_word_valid;
  logic                         save_word_taken;
  logic [ss_pkg::SS_DATA_W-1:0] load_word;
  logic                         load_word_valid;
  logic                         load_word_taken;
  logic                         save_busy;
  logic                         load_busy;
  logic                         save_done;
  logic                         load_done;
  logic                         save_fail;
  logic                         save_req;
  logic                         load_req;
  logic                         save_gnt;
  logic                         load_gnt;
  logic                         save_ready;
  logic                         load_ready;
  logic [ss_pkg::SS_ADDR_W-1:0] save_addr;
  logic [ss_pkg::SS_ADDR_W-1:0] load_addr;
  logic [ss_pkg::SS_DATA_W-1:0] load_wdata;
  logic                         load_wren;
  logic [ss_pkg::SS_ADDR_W-1:0] bus_addr;
  logic [ss_pkg::SS_DATA_W-1:0] bus_wdata;
  logic                         bus_wren;
  logic [ss_pkg::SS_DATA_W-1:0] bus_rdata;
  logic                         ss_halt;
  logic                         ss_ready;

  ss_bridge_regs u_bridge_regs (
    .clk_sys(clk_sys), .rst_n(rst_n),
    .bridge_wr(bridge_wr), .bridge_rd(bridge_rd),
    .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
    .bridge_rd_data(bridge_rd_data),
    .save_go(save_go), .load_go(load_go),
    .save_word(save_word), .save_word_valid(save_word_valid),
    .save_word_taken(save_word_taken),
    .load_word(load_word), .load_word_valid(load_word_valid),
    .load_word_taken(load_word_taken),
    .save_busy(save_busy), .load_busy(load_busy),
    .save_done(save_done), .load_done(load_done), .save_fail(save_fail)
  );

  ss_save_engine #(.SS_WORDS(SS_WORDS), .READ_LATENCY(READ_LATENCY)) u_save_engine (
    .clk_sys(clk_sys), .rst_n(rst_n),
    .save_go(save_go), .save_word_taken(save_word_taken),
    .sess_gnt(save_gnt), .ss_ready(save_ready), .bus_rdata(bus_rdata),
    .sess_req(save_req), .bus_addr(save_addr),
    .save_word(save_word), .save_word_valid(save_word_valid),
    .save_busy(save_busy), .save_done(save_done), .save_fail(save_fail)
  );

  ss_load_engine #(.SS_WORDS(SS_WORDS)) u_load_engine (
    .clk_sys(clk_sys), .rst_n(rst_n),
    .load_go(load_go), .load_word(load_word), .load_word_valid(load_word_valid),
    .sess_gnt(load_gnt), .ss_ready(load_ready),
    .sess_req(load_req), .bus_addr(load_addr), .bus_wdata(load_wdata),
    .bus_wren(load_wren), .load_word_taken(load_word_taken),
    .load_busy(load_busy), .load_done(load_done)
  );

  ss_bus_arbiter u_bus_arbiter (
    .clk_sys(clk_sys), .rst_n(rst_n),
    .save_req(save_req), .load_req(load_req),
    .save_gnt(save_gnt), .load_gnt(load_gnt),
    .save_addr(save_addr), .load_addr(load_addr),
    .load_wdata(load_wdata), .load_wren(load_wren),
    .ss_ready(ss_ready), .save_ready(save_ready), .load_ready(load_ready),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_wren(bus_wren),
    .ss_halt(ss_halt)
  );

  ss_state_store #(
    .SS_WORDS(SS_WORDS), .READ_LATENCY(READ_LATENCY), .READY_DELAY(READY_DELAY)
  ) u_state_store (
    .clk_sys(clk_sys), .rst_n(rst_n), .ss_halt(ss_halt),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_wren(bus_wren),
    .bus_rdata(bus_rdata), .ss_ready(ss_ready)
  );

endmodule

//--- tb_ss_top.sv
module tb_ss_top;

  localparam int WORDS      = 16;
  localparam int WAIT_LIMIT = 2000;

  logic        clk_sys;
  logic        rst_n;
  logic        bridge_wr;
  logic        bridge_rd;
  logic [31:0] bridge_addr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;

  // Expected content of the state store
  logic [31:0] ref_mem [WORDS];
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  bit          timed_out;

  ss_top #(.SS_WORDS(WORDS)) u_ss_top (
    .clk_sys(clk_sys),
    .rst_n(rst_n),
    .bridge_wr(bridge_wr),
    .bridge_rd(bridge_rd),
    .bridge_addr(bridge_addr),
    .bridge_wr_data(bridge_wr_data),
    .bridge_rd_data(bridge_rd_data)
  );

  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
  end

  // Host order starts with the least significant nibble
  function automatic logic [31:0] reverse_nibbles(input logic [31:0] w);
    return {w[3:0], w[7:4], w[11:8], w[15:12], w[19:16], w[23:20], w[27:24], w[31:28]};
  endfunction

  task automatic next_cycle();
    @(posedge clk_sys);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (!timed_out) begin
      assert (actual === expected)
      else begin
        $display("CHECK FAILED %s: expected %08h actual %08h", name, expected, actual);
        test_errors++;
      end
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    next_cycle();
    bridge_wr = 1'b0;
  endtask

  // Read data is registered and ready one cycle after the strobe
  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    bridge_rd   = 1'b1;
    bridge_addr = addr;
    next_cycle();
    bridge_rd = 1'b0;
    data      = bridge_rd_data;
  endtask

  task automatic wait_status_bit(input string name, input int bit_pos);
    logic [31:0] status;
    int          cycles;
    status = '0;
    cycles = 0;
    while (!timed_out && !status[bit_pos]) begin
      if (cycles == WAIT_LIMIT) begin
        $display("Timeout in %s: status bit %0d never came up", name, bit_pos);
        timed_out = 1'b1;
        test_errors++;
      end else begin
        read_reg(ss_pkg::SS_REG_STATUS, status);
        cycles++;
      end
    end
  endtask

  // Waits until the save or load word valid level reaches the given value
  task automatic wait_handoff(input string name, input bit save_side, input bit level);
    int cycles;
    cycles = 0;
    while (!timed_out && ((save_side ? u_ss_top.save_word_valid
                                     : u_ss_top.load_word_valid) !== level)) begin
      if (cycles == WAIT_LIMIT) begin
        $display("Timeout in %s: word handoff never happened", name);
        timed_out = 1'b1;
        test_errors++;
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  // Ack and busy show up together one cycle after the command write
  task automatic start_cmd(input string name, input int cmd_bit, input int field_lsb,
                           output logic [31:0] status);
    write_reg(ss_pkg::SS_REG_CMD, 32'd1 << cmd_bit);
    next_cycle();
    read_reg(ss_pkg::SS_REG_STATUS, status);
    check_value({name, " start flags"}, 32'h3, {28'd0, status[field_lsb +: 4]});
  endtask

  task automatic drain_save(input string name);
    logic [31:0] data;
    logic [31:0] status;
    for (int i = 0; i < WORDS; i++) begin
      wait_handoff(name, 1'b1, 1'b1);
      // Random host pause with a word pending keeps the engine stalled
      repeat (1 + $urandom_range(6, 0)) next_cycle();
      read_reg(ss_pkg::SS_REG_SAVE_DATA, data);
      check_value($sformatf("%s word %0d", name, i), reverse_nibbles(ref_mem[i]), data);
      wait_handoff(name, 1'b1, 1'b0);
    end
    wait_status_bit(name, ss_pkg::SS_ST_SAVE_OK);
    read_reg(ss_pkg::SS_REG_STATUS, status);
    check_value({name, " save flags"}, 32'h4, {28'd0, status[3:0]});
  endtask

  task automatic push_load(input string name);
    logic [31:0] status;
    for (int i = 0; i < WORDS; i++) begin
      ref_mem[i] = $urandom;
      wait_handoff(name, 1'b0, 1'b0);
      write_reg(ss_pkg::SS_REG_LOAD_DATA, reverse_nibbles(ref_mem[i]));
    end
    wait_status_bit(name, ss_pkg::SS_ST_LOAD_OK);
    read_reg(ss_pkg::SS_REG_STATUS, status);
    check_value({name, " load flags"}, 32'h4, {28'd0, status[7:4]});
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0 && !timed_out) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("FAIL %s", name);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    logic [31:0] status;
    void'($urandom(32'hf990_9241));
    rst_n          = 1'b0;
    bridge_wr      = 1'b0;
    bridge_rd      = 1'b0;
    bridge_addr    = '0;
    bridge_wr_data = '0;
    test_errors    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    timed_out      = 1'b0;
    for (int i = 0; i < WORDS; i++) begin
      ref_mem[i] = i * 32'h0101_0101;
    end
    repeat (4) @(posedge clk_sys);
    #2;
    rst_n = 1'b1;
    next_cycle();

    read_reg(ss_pkg::SS_REG_STATUS, status);
    check_value("reset status", 32'h0, status);
    end_test("reset status");

    start_cmd("save after reset", ss_pkg::SS_CMD_SAVE_BIT, 0, status);
    drain_save("save after reset");
    end_test("save after reset");

    start_cmd("load then save", ss_pkg::SS_CMD_LOAD_BIT, 4, status);
    push_load("load then save");
    start_cmd("load then save", ss_pkg::SS_CMD_SAVE_BIT, 0, status);
    check_value("load then save load ok cleared", 32'h0, {31'd0, status[6]});
    drain_save("load then save");
    end_test("load then save");

    // Load command lands while the save session is running
    start_cmd("busy rejection", ss_pkg::SS_CMD_SAVE_BIT, 0, status);
    write_reg(ss_pkg::SS_REG_CMD, 32'd1 << ss_pkg::SS_CMD_LOAD_BIT);
    read_reg(ss_pkg::SS_REG_STATUS, status);
    check_value("busy rejection load flags", 32'h8, {28'd0, status[7:4]});
    drain_save("busy rejection");
    end_test("busy rejection");

    read_reg(ss_pkg::SS_REG_STATUS, status);
    check_value("flag clearing load err before", 32'h1, {31'd0, status[7]});
    start_cmd("flag clearing", ss_pkg::SS_CMD_SAVE_BIT, 0, status);
    check_value("flag clearing load ok and err", 32'h0, {30'd0, status[7:6]});
    drain_save("flag clearing");
    end_test("flag clearing");

    $display("Tests run: %0d, passed: %0d, failed: %0d",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- savestate.f
ss_pkg.sv
ss_bridge_regs.sv
ss_save_engine.sv
ss_load_engine.sv
ss_bus_arbiter.sv
ss_state_store.sv
ss_top.sv
tb_ss_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ss_top \
  -f savestate.f -o sim_tb_ss_top || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb_ss_top | tee sim.log

grep -q "Regression failed" sim.log && { echo "Simulation reported a failure"; exit 1; } || exit 0
